// ==== design/isa_pkg.sv ====
package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    // primary opcodes
    localparam logic [5:0] SPE    = 6'b000000;
    localparam logic [5:0] REGIMM = 6'b000001;
    localparam logic [5:0] J      = 6'b000010;
    localparam logic [5:0] JAL    = 6'b000011;
    localparam logic [5:0] BEQ    = 6'b000100;
    localparam logic [5:0] BNE    = 6'b000101;
    localparam logic [5:0] BLEZ   = 6'b000110;
    localparam logic [5:0] BGTZ   = 6'b000111;
    localparam logic [5:0] ADDI   = 6'b001000;
    localparam logic [5:0] ADDIU  = 6'b001001;
    localparam logic [5:0] SLTI   = 6'b001010;
    localparam logic [5:0] SLTIU  = 6'b001011;
    localparam logic [5:0] ANDI   = 6'b001100;
    localparam logic [5:0] ORI    = 6'b001101;
    localparam logic [5:0] XORI   = 6'b001110;
    localparam logic [5:0] LUI    = 6'b001111;
    localparam logic [5:0] COP0   = 6'b010000;
    localparam logic [5:0] SPE2   = 6'b011100;
    localparam logic [5:0] LB     = 6'b100000;
    localparam logic [5:0] LH     = 6'b100001;
    localparam logic [5:0] LW     = 6'b100011;
    localparam logic [5:0] LBU    = 6'b100100;
    localparam logic [5:0] LHU    = 6'b100101;
    localparam logic [5:0] SB     = 6'b101000;
    localparam logic [5:0] SH     = 6'b101001;
    localparam logic [5:0] SW     = 6'b101011;

    // function field
    localparam logic [5:0] SLL  = 6'b000000;
    localparam logic [5:0] SRL  = 6'b000010;
    localparam logic [5:0] SRA  = 6'b000011;
    localparam logic [5:0] JR   = 6'b001000;
    localparam logic [5:0] JALR = 6'b001001;
    localparam logic [5:0] MTHI = 6'b010001;
    localparam logic [5:0] MTLO = 6'b010011;
    localparam logic [5:0] MUL  = 6'b000010;   // under SPE2
    localparam logic [5:0] ERET = 6'b011000;   // under COP0

    // REGIMM selectors, carried in rt
    localparam logic [4:0] BLTZ   = 5'b00000;
    localparam logic [4:0] BGEZ   = 5'b00001;
    localparam logic [4:0] BLTZAL = 5'b10000;
    localparam logic [4:0] BGEZAL = 5'b10001;

    // COP0 selectors, carried in rs
    localparam logic [4:0] MFC0 = 5'b00000;
    localparam logic [4:0] MTC0 = 5'b00100;

    localparam logic [5:0] EXC_NONE      = 6'h00;
    localparam logic [5:0] EXC_RI        = 6'h2a;
    localparam logic [5:0] EXC_SELF_JUMP = 6'h20;
    localparam int         EXC_BIT       = 5;   // exception present

    localparam reg_idx_t LINK_REG = 5'd31;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    typedef logic [31:0] word_t;

    // fetched instruction, split into fields
    typedef struct packed {
        logic [31:0] pc;
        logic [5:0]  icode;
        logic [5:0]  acode;
        logic [5:0]  exc_code;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic        in_delay_slot;
    } fd_bundle_t;

    // a later-stage result, dst of zero means no write
    typedef struct packed {
        logic [4:0]  dst;
        logic [31:0] val;
    } fwd_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] val1;
        logic [31:0] val2;
        logic [31:0] valt;    // store data
        logic [31:0] jaddr;
        logic [5:0]  icode;
        logic [5:0]  acode;
        logic [5:0]  exc_code;
        logic [4:0]  dst;
        logic        jump;
        logic        is_jump;
        logic        in_delay_slot;
        logic        is_eret;
    } dec_out_t;

    typedef struct packed {
        logic        write;
        logic [4:0]  idx;
        logic [31:0] data;
    } cp0_req_t;

    typedef struct packed {
        logic        hi_write;
        logic        lo_write;
        logic [31:0] data;
    } hilo_req_t;

endpackage

// ==== design/decode_latch.sv ====
`timescale 1ns/1ps

module decode_latch (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 stall,
    input  logic                 bubble,
    input  pipe_pkg::fd_bundle_t f_in,
    output pipe_pkg::fd_bundle_t d_q
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fd_bundle_t cleared;
    fd_bundle_t killed;

    // no-op, pc left as is
    always_comb begin
        cleared = '0;
        cleared.pc = d_q.pc;
    end

    // faulting fetch becomes a no-op that still carries its code
    always_comb begin
        killed = '0;
        killed.pc = f_in.pc;
        killed.exc_code = f_in.exc_code;
        killed.in_delay_slot = f_in.in_delay_slot;
    end

    always_ff @(posedge clk) begin
        if (!resetn || (!stall && bubble)) begin
            d_q <= cleared;
        end else if (!stall) begin
            d_q <= f_in.exc_code[EXC_BIT] ? killed : f_in;
        end
    end

endmodule

// ==== design/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file (
    input  logic           clk,
    input  logic           resetn,
    input  logic [4:0]     raddr1,
    input  logic [4:0]     raddr2,
    input  pipe_pkg::fwd_t wr,
    output logic [31:0]    rd1,
    output logic [31:0]    rd2
);
    import pipe_pkg::*;

    word_t regs [1:31];   // r0 is not stored

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.dst != 5'd0) begin
            regs[wr.dst] <= wr.val;
        end
    end

    always_comb begin
        if (raddr1 == 5'd0) begin
            rd1 = '0;
        end else begin
            rd1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == 5'd0) begin
            rd2 = '0;
        end else begin
            rd2 = regs[raddr2];
        end
    end

endmodule

// ==== design/operand_fwd.sv ====
`timescale 1ns/1ps

module operand_fwd (
    input  logic [4:0]     src1,
    input  logic [4:0]     src2,
    input  pipe_pkg::fwd_t e_fwd,
    input  pipe_pkg::fwd_t m_fwd,
    input  pipe_pkg::fwd_t w_fwd,
    input  logic [31:0]    rd1,
    input  logic [31:0]    rd2,
    output logic [4:0]     raddr1,
    output logic [4:0]     raddr2,
    output logic [31:0]    op1,
    output logic [31:0]    op2
);
    import pipe_pkg::*;

    // youngest result wins
    function automatic word_t pick(input logic [4:0] idx, input word_t rf,
                                   input fwd_t e, input fwd_t m, input fwd_t w);
        if (idx == 5'd0) begin
            return '0;
        end else if (idx == e.dst) begin
            return e.val;
        end else if (idx == m.dst) begin
            return m.val;
        end else if (idx == w.dst) begin
            return w.val;
        end
        return rf;
    endfunction

    assign raddr1 = src1;
    assign raddr2 = src2;

    assign op1 = pick(src1, rd1, e_fwd, m_fwd, w_fwd);
    assign op2 = pick(src2, rd2, e_fwd, m_fwd, w_fwd);

endmodule

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  pipe_pkg::fd_bundle_t d_q,
    input  logic [31:0]          op1,
    input  logic [31:0]          op2,
    input  logic [31:0]          f_pc,
    input  logic [31:0]          pred_pc,
    input  logic [31:0]          cp0_val,
    input  logic [31:0]          epc,
    output logic [4:0]           src1,
    output logic [4:0]           src2,
    output pipe_pkg::dec_out_t   d_out,
    output pipe_pkg::cp0_req_t   cp0_req,
    output pipe_pkg::hilo_req_t  hilo_req
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [15:0] imm;
    word_t       imm_se, imm_val, val1, jaddr;
    logic        is_imm_op, is_load, is_store, is_link_br, is_spe_jr;
    logic        legal, jump, is_jump, is_eret;
    reg_idx_t    dst;

    assign imm    = {d_q.rd, d_q.sa, d_q.acode};
    assign imm_se = {{16{imm[15]}}, imm};

    assign is_imm_op = d_q.icode inside {ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU};
    assign is_load   = d_q.icode inside {LB, LBU, LH, LHU, LW};
    assign is_store  = d_q.icode inside {SB, SH, SW};
    assign is_link_br = d_q.icode == REGIMM && d_q.rt inside {BGEZAL, BLTZAL};
    assign is_spe_jr  = d_q.icode == SPE && d_q.acode inside {JR, JALR};
    assign is_eret    = d_q.icode == COP0 && d_q.acode == ERET;

    assign src1 = d_q.rs;
    assign src2 = (d_q.icode == REGIMM) ? 5'd0 : d_q.rt;   // rt is the selector there

    always_comb begin
        case (d_q.icode)
            ANDI, ORI, XORI: imm_val = {16'h0000, imm};
            LUI:             imm_val = {imm, 16'h0000};
            default:         imm_val = imm_se;
        endcase
    end

    always_comb begin
        dst = '0;
        if (is_imm_op || is_load) begin
            dst = d_q.rt;
        end else if (d_q.icode == SPE) begin
            dst = (d_q.acode == JR) ? 5'd0 : d_q.rd;
        end else if (d_q.icode == SPE2) begin
            dst = d_q.rd;
        end else if (d_q.icode == JAL || is_link_br) begin
            dst = LINK_REG;
        end else if (d_q.icode == COP0 && d_q.rs == MFC0) begin
            dst = d_q.rt;
        end
    end

    always_comb begin
        if (d_q.icode == J || d_q.icode == LUI) begin
            val1 = '0;
        end else if (d_q.icode == SPE && d_q.acode inside {SLL, SRL, SRA}) begin
            val1 = {27'd0, d_q.sa};   // shift amount
        end else if (d_q.icode == COP0) begin
            val1 = cp0_val;
        end else begin
            val1 = op1;
        end
    end

    always_comb begin
        if (d_q.icode == J || d_q.icode == JAL) begin
            jaddr = {d_q.pc[31:28], d_q.rs, d_q.rt, imm, 2'b00};
        end else if (is_spe_jr) begin
            jaddr = op1;
        end else if (d_q.icode == COP0) begin
            jaddr = epc;
        end else begin
            jaddr = f_pc + {imm_se[29:0], 2'b00};   // relative to delay slot
        end
    end

    // branch resolution
    always_comb begin
        jump = 1'b0;
        is_jump = 1'b1;
        case (d_q.icode)
            BEQ:    jump = op1 == op2;
            BNE:    jump = op1 != op2;
            BGTZ:   jump = $signed(op1) > 32'sd0;
            BLEZ:   jump = $signed(op1) <= 32'sd0;
            J, JAL: jump = 1'b1;
            REGIMM: begin
                case (d_q.rt)
                    BGEZ, BGEZAL: jump = !op1[31];
                    BLTZ, BLTZAL: jump = op1[31];
                    default:      is_jump = 1'b0;
                endcase
            end
            SPE: begin
                jump = is_spe_jr;
                is_jump = is_spe_jr;
            end
            COP0: begin
                jump = is_eret;
                is_jump = is_eret;
            end
            default: is_jump = 1'b0;
        endcase
    end

    always_comb begin
        case (d_q.icode)
            SPE, REGIMM, J, JAL, BEQ, BNE, BLEZ, BGTZ,
            ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI, COP0,
            LB, LH, LW, LBU, LHU, SB, SH, SW: legal = 1'b1;
            SPE2:    legal = d_q.acode == MUL;
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        d_out.pc            = d_q.pc;
        d_out.icode         = d_q.icode;
        d_out.acode         = d_q.acode;
        d_out.in_delay_slot = d_q.in_delay_slot;
        d_out.dst           = dst;
        d_out.val1          = val1;
        d_out.valt          = is_store ? op2 : '0;
        d_out.jaddr         = jaddr;
        d_out.jump          = jump;
        d_out.is_jump       = is_jump;
        d_out.is_eret       = is_eret;

        if (is_imm_op || is_load || is_store) begin
            d_out.val2 = imm_val;
        end else if (d_q.icode == JAL || is_link_br ||
                     (d_q.icode == SPE && d_q.acode == JALR)) begin
            d_out.val2 = pred_pc;   // link value
        end else if (d_q.icode == SPE || d_q.icode == SPE2) begin
            d_out.val2 = op2;
        end else begin
            d_out.val2 = '0;
        end

        if (d_q.exc_code[EXC_BIT]) begin
            d_out.exc_code = d_q.exc_code;   // from fetch
        end else if (!legal) begin
            d_out.exc_code = EXC_RI;
        end else if (jump && jaddr == d_q.pc) begin
            d_out.exc_code = EXC_SELF_JUMP;
        end else begin
            d_out.exc_code = EXC_NONE;
        end
    end

    assign cp0_req.write = d_q.icode == COP0 && d_q.rs == MTC0;
    assign cp0_req.idx   = d_q.rd;
    assign cp0_req.data  = op2;

    assign hilo_req.hi_write = d_q.icode == SPE && d_q.acode == MTHI;
    assign hilo_req.lo_write = d_q.icode == SPE && d_q.acode == MTLO;
    assign hilo_req.data     = val1;

endmodule

// ==== design/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  pipe_pkg::fd_bundle_t f_in,
    input  logic                 stall,
    input  logic                 bubble,
    input  logic [31:0]          f_pc,
    input  logic [31:0]          pred_pc,
    input  pipe_pkg::fwd_t       e_fwd,
    input  pipe_pkg::fwd_t       m_fwd,
    input  pipe_pkg::fwd_t       w_fwd,
    input  logic [31:0]          cp0_val,
    input  logic [31:0]          epc,
    output pipe_pkg::dec_out_t   d_out,
    output pipe_pkg::cp0_req_t   cp0_req,
    output pipe_pkg::hilo_req_t  hilo_req
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fd_bundle_t d_q;
    reg_idx_t   src1, src2, raddr1, raddr2;
    word_t      rd1, rd2, op1, op2;

    decode_latch u_latch (
        .clk    (clk),
        .resetn (resetn),
        .stall  (stall),
        .bubble (bubble),
        .f_in   (f_in),
        .d_q    (d_q)
    );

    gpr_file u_gpr (
        .clk    (clk),
        .resetn (resetn),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wr     (w_fwd),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    operand_fwd u_fwd (
        .src1   (src1),
        .src2   (src2),
        .e_fwd  (e_fwd),
        .m_fwd  (m_fwd),
        .w_fwd  (w_fwd),
        .rd1    (rd1),
        .rd2    (rd2),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .op1    (op1),
        .op2    (op2)
    );

    decode_unit u_dec (
        .d_q      (d_q),
        .op1      (op1),
        .op2      (op2),
        .f_pc     (f_pc),
        .pred_pc  (pred_pc),
        .cp0_val  (cp0_val),
        .epc      (epc),
        .src1     (src1),
        .src2     (src2),
        .d_out    (d_out),
        .cp0_req  (cp0_req),
        .hilo_req (hilo_req)
    );

endmodule

// ==== bench/decode_props.sv ====
`timescale 1ns/1ps

module decode_props (
    input logic                 clk,
    input logic                 resetn,
    input logic                 stall,
    input pipe_pkg::fd_bundle_t d_q,
    input pipe_pkg::dec_out_t   d_out,
    input pipe_pkg::hilo_req_t  hilo_req
);

    int fails = 0;   // failed assertions so far

    hilo_one_side: assert property (@(posedge clk) disable iff (!resetn)
        !(hilo_req.hi_write && hilo_req.lo_write))
        else begin
            fails++;
            $error("hi and lo writes requested together");
        end

    eret_jumps: assert property (@(posedge clk) disable iff (!resetn)
        d_out.is_eret |-> d_out.jump)
        else begin
            fails++;
            $error("eret decoded without a jump");
        end

    jump_flagged: assert property (@(posedge clk) disable iff (!resetn)
        d_out.jump |-> d_out.is_jump)
        else begin
            fails++;
            $error("jump taken by a non control-transfer instruction");
        end

    // stall freezes the decode latch
    stall_holds: assert property (@(posedge clk) disable iff (!resetn)
        stall |=> d_q === $past(d_q))
        else begin
            fails++;
            $error("latched bundle changed while stalled");
        end

endmodule

bind decode_top decode_props u_props (
    .clk      (clk),
    .resetn   (resetn),
    .stall    (stall),
    .d_q      (d_q),
    .d_out    (d_out),
    .hilo_req (hilo_req)
);

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int RESET_CYCLES   = 4;
    localparam int N_CYCLES       = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_CYCLES + 96;
    localparam logic [31:0] TAPS  = 32'h8020_0003;

    logic        clk;
    logic        resetn;
    logic        stall;
    logic        bubble;
    fd_bundle_t  f_in;
    logic [31:0] f_pc, pred_pc, cp0_val, epc;
    fwd_t        e_fwd, m_fwd, w_fwd;
    dec_out_t    d_out;
    cp0_req_t    cp0_req;
    hilo_req_t   hilo_req;

    logic [31:0] lfsr = 32'hfdec_3cae;
    fd_bundle_t  sh;            // shadow of the decode latch
    logic [31:0] sregs [32];    // shadow register file
    dec_out_t    ed;
    cp0_req_t    ec;
    hilo_req_t   eh;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    logic [5:0] opcodes [26] = '{SPE, SPE2, ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
                                 BEQ, BNE, BGTZ, BLEZ, REGIMM, J, JAL, LB, LBU, LH, LHU,
                                 LW, SB, SH, SW, COP0};
    logic [5:0] funcs [9] = '{SLL, SRL, SRA, JR, JALR, MTHI, MTLO, MUL, ERET};

    decode_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? TAPS : 32'h0);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] operand(input logic [4:0] idx);
        if (idx == 5'd0) return 32'h0;
        if (idx == e_fwd.dst) return e_fwd.val;
        if (idx == m_fwd.dst) return m_fwd.val;
        if (idx == w_fwd.dst) return w_fwd.val;
        return sregs[idx];
    endfunction

    task automatic update_model();
        fd_bundle_t nxt;
        nxt = sh;
        if (!resetn || (!stall && bubble)) begin
            nxt = '0;
            nxt.pc = sh.pc;
        end else if (!stall && f_in.exc_code[5]) begin
            nxt = '0;   // killed instruction keeps only its exception
            nxt.pc = f_in.pc;
            nxt.exc_code = f_in.exc_code;
            nxt.in_delay_slot = f_in.in_delay_slot;
        end else if (!stall) begin
            nxt = f_in;
        end
        sh = nxt;
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                sregs[i] = 32'h0;
            end
        end else if (w_fwd.dst != 5'd0) begin
            sregs[w_fwd.dst] = w_fwd.val;
        end
    endtask

    task automatic drive_random();
        logic [15:0] imm;
        f_in.pc = rand_bits(32);
        f_in.icode = (rand_bits(3) != 0) ? opcodes[rand_bits(5) % 26] : 6'(rand_bits(6));
        f_in.acode = rand_bits(1) ? funcs[rand_bits(4) % 9] : 6'(rand_bits(6));
        f_in.exc_code = {rand_bits(4) == 0, 5'(rand_bits(5))};
        f_in.rs = 5'(rand_bits(3));
        f_in.rt = rand_bits(1) ? 5'(rand_bits(3)) : {1'(rand_bits(1)), 3'b000, 1'(rand_bits(1))};
        f_in.rd = (rand_bits(2) == 0) ? 5'(rand_bits(5)) : 5'(rand_bits(3));
        f_in.sa = 5'(rand_bits(5));
        f_in.in_delay_slot = 1'(rand_bits(1));
        stall = rand_bits(3) == 0;
        bubble = rand_bits(3) == 0;
        e_fwd = {5'(rand_bits(3)), rand_bits(32)};
        m_fwd = {5'(rand_bits(3)), rand_bits(32)};
        w_fwd = {5'(rand_bits(3)), rand_bits(32)};
        pred_pc = rand_bits(32);
        cp0_val = rand_bits(32);
        epc = rand_bits(32);
        imm = {sh.rd, sh.sa, sh.acode};
        if (rand_bits(3) == 0) begin
            f_pc = sh.pc - {{14{imm[15]}}, imm, 2'b00};   // relative target hits pc
        end else begin
            f_pc = rand_bits(32);
        end
    endtask

    task automatic predict();
        logic [15:0] imm;
        logic [31:0] se, a, b;
        logic        imm_op, ld, st, lnk, jr, legal;
        imm = {sh.rd, sh.sa, sh.acode};
        se = {{16{imm[15]}}, imm};
        a = operand(sh.rs);
        b = operand((sh.icode == REGIMM) ? 5'd0 : sh.rt);
        imm_op = sh.icode inside {ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU};
        ld = sh.icode inside {LB, LBU, LH, LHU, LW};
        st = sh.icode inside {SB, SH, SW};
        lnk = sh.icode == REGIMM && sh.rt inside {BGEZAL, BLTZAL};
        jr = sh.icode == SPE && sh.acode inside {JR, JALR};
        legal = sh.icode inside {SPE, REGIMM, J, JAL, BEQ, BNE, BLEZ, BGTZ, ADDI, ADDIU,
                                 SLTI, SLTIU, ANDI, ORI, XORI, LUI, COP0, LB, LH, LW,
                                 LBU, LHU, SB, SH, SW} || (sh.icode == SPE2 && sh.acode == MUL);
        ed = '0;
        ed.pc = sh.pc;
        ed.icode = sh.icode;
        ed.acode = sh.acode;
        ed.in_delay_slot = sh.in_delay_slot;
        ed.is_eret = sh.icode == COP0 && sh.acode == ERET;
        ed.valt = st ? b : 32'h0;
        if (imm_op || ld) ed.dst = sh.rt;
        else if (sh.icode == SPE) ed.dst = (sh.acode == JR) ? 5'd0 : sh.rd;
        else if (sh.icode == SPE2) ed.dst = sh.rd;
        else if (sh.icode == JAL || lnk) ed.dst = LINK_REG;
        else if (sh.icode == COP0 && sh.rs == MFC0) ed.dst = sh.rt;
        if (sh.icode == J || sh.icode == LUI) ed.val1 = 32'h0;
        else if (sh.icode == SPE && sh.acode inside {SLL, SRL, SRA}) ed.val1 = sh.sa;
        else if (sh.icode == COP0) ed.val1 = cp0_val;
        else ed.val1 = a;
        if (sh.icode inside {ANDI, ORI, XORI}) ed.val2 = {16'h0, imm};
        else if (sh.icode == LUI) ed.val2 = {imm, 16'h0};
        else if (imm_op || ld || st) ed.val2 = se;
        else if (sh.icode == JAL || lnk || (sh.icode == SPE && sh.acode == JALR)) ed.val2 = pred_pc;
        else if (sh.icode == SPE || sh.icode == SPE2) ed.val2 = b;
        if (sh.icode == J || sh.icode == JAL) begin
            ed.jaddr = {sh.pc[31:28], sh.rs, sh.rt, sh.rd, sh.sa, sh.acode, 2'b00};
        end else if (jr) ed.jaddr = a;
        else if (sh.icode == COP0) ed.jaddr = epc;
        else ed.jaddr = f_pc + (se << 2);
        case (sh.icode)
            BEQ, BNE, BGTZ, BLEZ: ed.is_jump = 1'b1;
            J, JAL:  {ed.jump, ed.is_jump} = 2'b11;
            REGIMM:  ed.is_jump = sh.rt inside {BLTZ, BGEZ, BLTZAL, BGEZAL};
            SPE:     {ed.jump, ed.is_jump} = {2{jr}};
            COP0:    {ed.jump, ed.is_jump} = {2{ed.is_eret}};
            default: ;
        endcase
        case (sh.icode)
            BEQ:     ed.jump = a == b;
            BNE:     ed.jump = a != b;
            BGTZ:    ed.jump = $signed(a) > 0;
            BLEZ:    ed.jump = $signed(a) <= 0;
            REGIMM:  ed.jump = ed.is_jump && (sh.rt[0] ? !a[31] : a[31]);   // bit 0 marks GEZ
            default: ;
        endcase
        if (sh.exc_code[5]) ed.exc_code = sh.exc_code;
        else if (!legal) ed.exc_code = 6'h2a;
        else if (ed.jump && ed.jaddr == sh.pc) ed.exc_code = 6'h20;
        ec.write = sh.icode == COP0 && sh.rs == MTC0;
        ec.idx = sh.rd;
        ec.data = b;
        eh.hi_write = sh.icode == SPE && sh.acode == MTHI;
        eh.lo_write = sh.icode == SPE && sh.acode == MTLO;
        eh.data = ed.val1;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_outputs();
        predict();
        check_val("d_out.pc", ed.pc, d_out.pc);
        check_val("d_out.val1", ed.val1, d_out.val1);
        check_val("d_out.val2", ed.val2, d_out.val2);
        check_val("d_out.valt", ed.valt, d_out.valt);
        check_val("d_out.jaddr", ed.jaddr, d_out.jaddr);
        check_val("d_out.icode", ed.icode, d_out.icode);
        check_val("d_out.acode", ed.acode, d_out.acode);
        check_val("d_out.exc_code", ed.exc_code, d_out.exc_code);
        check_val("d_out.dst", ed.dst, d_out.dst);
        check_val("d_out.jump", ed.jump, d_out.jump);
        check_val("d_out.is_jump", ed.is_jump, d_out.is_jump);
        check_val("d_out.in_delay_slot", ed.in_delay_slot, d_out.in_delay_slot);
        check_val("d_out.is_eret", ed.is_eret, d_out.is_eret);
        check_val("cp0_req.write", ec.write, cp0_req.write);
        check_val("cp0_req.idx", ec.idx, cp0_req.idx);
        check_val("cp0_req.data", ec.data, cp0_req.data);
        check_val("hilo_req.hi_write", eh.hi_write, hilo_req.hi_write);
        check_val("hilo_req.lo_write", eh.lo_write, hilo_req.lo_write);
        check_val("hilo_req.data", eh.data, hilo_req.data);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        resetn = 1'b0;
        stall = 1'b0;
        bubble = 1'b0;
        f_in = '0;
        f_pc = '0;
        pred_pc = '0;
        cp0_val = '0;
        epc = '0;
        e_fwd = '0;
        m_fwd = '0;
        w_fwd = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            update_model();
            #1 resetn = (i == RESET_CYCLES - 1);
            #1 check_outputs();
        end
        for (int n = 0; n < N_CYCLES; n++) begin
            @(posedge clk);
            update_model();   // inputs are still those of the last cycle
            #1 drive_random();
            #1 check_outputs();
        end
        $display("errors: %0d of %0d checks, %0d assertion failures", errors, checks,
                 UUT.u_props.fails);
        if (errors == 0 && UUT.u_props.fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== mips_decode.f ====
design/isa_pkg.sv
design/pipe_pkg.sv
design/decode_latch.sv
design/gpr_file.sv
design/operand_fwd.sv
design/decode_unit.sv
design/decode_top.sv
bench/decode_props.sv
bench/decode_tb.sv
